// ==== all.f ====
common/core_pkg.sv
common/obi_pkg.sv
hw/pc_gen.sv
fetch/fetch_ctrl.sv
hw/if_id_reg.sv
hw/fetch_top.sv
test/tb_obi_mem.sv
test/fetch_asserts.sv
test/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing --top-module tb_fetch -f all.f -o sim_fetch
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    exit 1
fi
exit 0

// ==== test/tb_fetch.sv ====
// fetch front end testbench; relies on tb_obi_mem returning addr ^ 32'hA5A5_0000
`timescale 1ns/1ns

module tb_fetch;
    import core_pkg::*;
    import obi_pkg::*;

    localparam addr_t BOOT     = 32'h0000_0080;
    localparam instr_t KEY     = 32'hA5A5_0000;
    localparam int    TIMEOUT  = 200;

    logic       clk;
    logic       reset;
    logic       stall;
    logic       redirect;
    addr_t      redirect_pc;
    obi_req_t   obi_req;
    obi_rsp_t   obi_rsp;
    fetch_out_t id;
    logic       stall_gnt;
    logic       stall_rvalid;
    logic       gnt_hold;
    logic       data_wait;

    int          errors;
    addr_t       expected_pc;
    logic [31:0] rnd;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    fetch_top #(
        .BOOT_ADDR(BOOT)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .obi_req_o     (obi_req),
        .obi_rsp_i     (obi_rsp),
        .id_o          (id),
        .stall_gnt_o   (stall_gnt),
        .stall_rvalid_o(stall_rvalid)
    );

    tb_obi_mem u_mem (
        .clk        (clk),
        .reset      (reset),
        .req_i      (obi_req),
        .rsp_o      (obi_rsp),
        .gnt_hold_o (gnt_hold),
        .data_wait_o(data_wait)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report(input string name, input logic [64:0] got, input logic [64:0] exp);
        $display("Error: %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    // one instruction taken by decode in the cycle just ended
    task automatic check_item();
        if (id.pc != expected_pc) begin
            report("id_o.pc", 65'(id.pc), 65'(expected_pc));
        end
        if (id.instr != (id.pc ^ KEY)) begin
            report("id_o.instr", 65'(id.instr), 65'(id.pc ^ KEY));
        end
        expected_pc = id.pc + 32'd4;
    endtask

    task automatic take_item();
        int n;
        logic ok;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT && !ok; n++) begin
            @(posedge clk);
            if (id.valid && !stall) begin
                check_item();
                ok = 1'b1;
            end
            // a bubble reads as NOP
            if (!id.valid && id.instr !== NOP_INSTR) begin
                report("id_o.instr", 65'(id.instr), 65'(NOP_INSTR));
            end
        end
        if (!ok) begin
            $display("timeout waiting for a valid instruction on id_o");
            errors++;
        end
    endtask

    task automatic reset_test();
        int i;
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            // registers hold reset values from the second edge on
            if (i > 0) begin
                if (id.valid !== 1'b0) report("id_o.valid", 65'(id.valid), 65'(0));
                if (id.instr !== NOP_INSTR) report("id_o.instr", 65'(id.instr), 65'(NOP_INSTR));
                if (obi_req.req !== 1'b0) report("obi_req.req", 65'(obi_req.req), 65'(0));
                if (stall_gnt !== 1'b0) report("stall_gnt_o", 65'(stall_gnt), 65'(0));
                if (stall_rvalid !== 1'b0) report("stall_rvalid_o", 65'(stall_rvalid), 65'(0));
            end
        end
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        if (obi_req.req !== 1'b0) report("obi_req.req", 65'(obi_req.req), 65'(0));
    endtask

    task automatic seq_test();
        int i;
        expected_pc = BOOT;
        for (i = 0; i < 40; i++) begin
            take_item();
        end
    endtask

    task automatic stall_test();
        int got;
        int cycles;
        int span;
        logic prev_stall;
        fetch_out_t prev_id;
        got = 0;
        cycles = 0;
        span = 0;
        prev_stall = 1'b0;
        prev_id = id;
        while (got < 40 && cycles < 2000) begin
            @(negedge clk);
            if (span == 0) begin
                rnd = next_rand(rnd);
                stall = rnd[0];
                span = 1 + int'(rnd[3:1]);
            end
            span--;
            @(posedge clk);
            // register frozen across a stalled edge
            if (prev_stall && id != prev_id) begin
                report("id_o", id, prev_id);
            end
            if (id.valid && !stall) begin
                check_item();
                got++;
            end
            prev_stall = stall;
            prev_id = id;
            cycles++;
        end
        @(negedge clk);
        stall = 1'b0;
        if (got < 40) begin
            $display("timeout: only %0d instructions arrived under stall", got);
            errors++;
        end
    endtask

    // redirect while a read waits for gnt or for data
    task automatic redirect_test(input logic on_gnt, input addr_t target);
        int n;
        logic ok;
        int i;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT && !ok; n++) begin
            @(posedge clk);
            if (id.valid && !stall) begin
                check_item();
            end
            if (on_gnt ? stall_gnt : stall_rvalid) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            $display("timeout waiting for a request in flight before redirect");
            errors++;
        end
        @(negedge clk);
        redirect = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        // last word of the old path still reaches decode
        if (id.valid && !stall) begin
            check_item();
        end
        @(negedge clk);
        redirect = 1'b0;
        @(posedge clk);
        if (id.valid !== 1'b0) report("id_o.valid", 65'(id.valid), 65'(0));
        expected_pc = target;
        for (i = 0; i < 10; i++) begin
            take_item();
        end
    endtask

    task automatic flag_test();
        int n;
        logic exp_gnt;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (id.valid && !stall) begin
                check_item();
            end
            exp_gnt = obi_req.req && gnt_hold;
            if (stall_gnt !== exp_gnt) report("stall_gnt_o", 65'(stall_gnt), 65'(exp_gnt));
            if (stall_rvalid !== data_wait) begin
                report("stall_rvalid_o", 65'(stall_rvalid), 65'(data_wait));
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        errors = 0;
        expected_pc = BOOT;
        rnd = 32'h1593;
        reset_test();
        seq_test();
        stall_test();
        redirect_test(1'b0, 32'h0000_0400);
        redirect_test(1'b1, 32'h0000_0800);
        flag_test();
        $display("error count %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== test/fetch_asserts.sv ====
// bus protocol checks bound into fetch_ctrl; assumes at most three reads outstanding
`timescale 1ns/1ns

module fetch_asserts (
    input logic              clk,
    input logic              reset,
    input obi_pkg::obi_req_t obi_req_i,
    input obi_pkg::obi_rsp_t obi_rsp_i
);
    // reads granted but not yet answered
    logic [1:0] outstanding;

    always @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding
                           + {1'b0, obi_req_i.req && obi_rsp_i.gnt}
                           - {1'b0, obi_rsp_i.rvalid};
        end
    end

    // request and address stay put until granted
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        obi_req_i.req && !obi_rsp_i.gnt |=> obi_req_i.req && $stable(obi_req_i.addr))
        else $error("req dropped or addr changed before gnt");

    // fetch is a full word read
    a_read_only: assert property (@(posedge clk) disable iff (reset)
        !obi_req_i.we && obi_req_i.be == 4'b1111)
        else $error("write or partial byte enable on fetch bus");

    a_rvalid_owned: assert property (@(posedge clk) disable iff (reset)
        obi_rsp_i.rvalid |-> outstanding != 2'd0)
        else $error("rvalid with no read in flight");

endmodule

bind fetch_ctrl fetch_asserts u_fetch_asserts (
    .clk      (clk),
    .reset    (reset),
    .obi_req_i(obi_req_o),
    .obi_rsp_i(obi_rsp_i)
);

// ==== test/tb_obi_mem.sv ====
// behavioral instruction memory; read only, word = addr ^ 32'hA5A5_0000, random gnt and data delay
`timescale 1ns/1ns

module tb_obi_mem (
    input  logic              clk,
    input  logic              reset,
    input  obi_pkg::obi_req_t req_i,
    output obi_pkg::obi_rsp_t rsp_o,
    // memory is holding back the grant
    output logic              gnt_hold_o,
    // a granted read has not returned its data yet
    output logic              data_wait_o
);
    import obi_pkg::*;

    localparam bus_data_t DATA_KEY = 32'hA5A5_0000;

    logic [31:0] seed;
    // request cycles left before the grant
    int          gnt_cnt;
    logic        gnt_ready;
    // accepted reads, oldest first
    bus_addr_t   q_addr[$];
    int          q_wait[$];
    logic        rvalid_q;
    bus_data_t   rdata_q;
    logic        busy_q;
    // bus events seen at the rising edge
    logic        took_req;
    logic        took_wait;
    logic        took_rvalid;
    bus_addr_t   took_addr;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        seed        = 32'h1593;
        gnt_cnt     = 0;
        gnt_ready   = 1'b1;
        rvalid_q    = 1'b0;
        rdata_q     = '0;
        busy_q      = 1'b0;
        took_req    = 1'b0;
        took_wait   = 1'b0;
        took_rvalid = 1'b0;
        took_addr   = '0;
    end

    // sample the handshake where it is stable
    always @(posedge clk) begin
        took_req    = req_i.req && rsp_o.gnt;
        took_wait   = req_i.req && !rsp_o.gnt;
        took_rvalid = rsp_o.rvalid;
        took_addr   = req_i.addr;
    end

    // update the responses on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            q_addr.delete();
            q_wait.delete();
            gnt_cnt = 0;
        end else begin
            if (took_rvalid) begin
                void'(q_addr.pop_front());
                void'(q_wait.pop_front());
            end else if (q_wait.size() != 0) begin
                if (q_wait[0] > 0) begin
                    q_wait[0] = q_wait[0] - 1;
                end
            end
            if (took_req) begin
                // data 1 to 3 cycles after the grant
                seed = xorshift32(seed);
                q_addr.push_back(took_addr);
                q_wait.push_back(int'(seed % 3));
                // grant for the next request after 0 to 3 cycles
                seed = xorshift32(seed);
                gnt_cnt = int'(seed % 4);
            end else if (took_wait && gnt_cnt > 0) begin
                gnt_cnt = gnt_cnt - 1;
            end
        end
        gnt_ready = (gnt_cnt == 0);
        rvalid_q  = 1'b0;
        rdata_q   = '0;
        if (q_wait.size() != 0) begin
            if (q_wait[0] == 0) begin
                rvalid_q = 1'b1;
                rdata_q  = q_addr[0] ^ DATA_KEY;
            end
        end
        busy_q = (q_addr.size() != 0) && !rvalid_q;
    end

    assign rsp_o.gnt    = req_i.req && gnt_ready;
    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;
    assign gnt_hold_o   = !gnt_ready;
    assign data_wait_o  = busy_q;

endmodule

// ==== hw/fetch_top.sv ====
// fetch front end top; instruction memory must follow OBI req/gnt/rvalid with in-order data
`timescale 1ns/1ns

module fetch_top #(
    parameter core_pkg::addr_t BOOT_ADDR = 32'h0000_0080
) (
    input  logic                 clk,
    input  logic                 reset,
    // decode stall
    input  logic                 stall_i,
    // redirect strobe and its target
    input  logic                 redirect_i,
    input  core_pkg::addr_t      redirect_pc_i,
    // instruction memory bus
    output obi_pkg::obi_req_t    obi_req_o,
    input  obi_pkg::obi_rsp_t    obi_rsp_i,
    // to decode
    output core_pkg::fetch_out_t id_o,
    output logic                 stall_gnt_o,
    output logic                 stall_rvalid_o
);
    import core_pkg::*;

    // current fetch address
    addr_t      pc;
    // granted request, step the pc
    logic       pc_take;
    // instruction leaving fetch
    fetch_out_t fetch;

    // address source
    pc_gen #(
        .BOOT_ADDR(BOOT_ADDR)
    ) u_pc_gen (
        .clk          (clk),
        .reset        (reset),
        .pc_take_i    (pc_take),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .pc_o         (pc)
    );

    // bus master
    fetch_ctrl u_fetch_ctrl (
        .clk           (clk),
        .reset         (reset),
        .pc_i          (pc),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .obi_req_o     (obi_req_o),
        .obi_rsp_i     (obi_rsp_i),
        .pc_take_o     (pc_take),
        .fetch_o       (fetch),
        .stall_gnt_o   (stall_gnt_o),
        .stall_rvalid_o(stall_rvalid_o)
    );

    // redirect doubles as the flush
    if_id_reg u_if_id_reg (
        .clk    (clk),
        .reset  (reset),
        .stall_i(stall_i),
        .flush_i(redirect_i),
        .fetch_i(fetch),
        .id_o   (id_o)
    );

endmodule

// ==== hw/if_id_reg.sv ====
// fetch/decode register; flush beats stall, an empty slot always reads as NOP
`timescale 1ns/1ns

module if_id_reg (
    input  logic                 clk,
    input  logic                 reset,
    // decode not ready, keep current entry
    input  logic                 stall_i,
    // redirect, empty the slot
    input  logic                 flush_i,
    input  core_pkg::fetch_out_t fetch_i,
    output core_pkg::fetch_out_t id_o
);
    import core_pkg::*;

    fetch_out_t id_q;

    // entry as it would be loaded
    fetch_out_t id_d;

    // bubble never carries a stale word
    always_comb begin
        id_d.valid = fetch_i.valid;
        id_d.pc    = fetch_i.pc;
        if (fetch_i.valid) begin
            id_d.instr = fetch_i.instr;
        end else begin
            id_d.instr = NOP_INSTR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            // empty slot, decode sees a NOP
            id_q <= FETCH_EMPTY;
        end else if (!stall_i) begin
            id_q <= id_d;
        end
        // stall keeps id_q as is
    end

    // one cycle behind fetch_i
    assign id_o = id_q;

endmodule

// ==== fetch/fetch_ctrl.sv ====
// OBI read master for fetch; one request in flight plus a chained one on rvalid, one held word
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::addr_t      pc_i,
    input  logic                 stall_i,
    input  logic                 redirect_i,
    output obi_pkg::obi_req_t    obi_req_o,
    input  obi_pkg::obi_rsp_t    obi_rsp_i,
    output logic                 pc_take_o,
    output core_pkg::fetch_out_t fetch_o,
    output logic                 stall_gnt_o,
    output logic                 stall_rvalid_o
);
    import core_pkg::*;
    import obi_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        WAIT_RVALID
    } state_t;

    state_t    state_q;
    state_t    state_d;

    // set one cycle after reset, keeps req low through reset
    logic      run_q;
    // pending request in WAIT_GNT belongs to a path left by redirect
    logic      stale_q;
    // response of the granted request is to be thrown away
    logic      drop_q;
    // address of a request still waiting for its grant
    bus_addr_t pend_addr_q;
    // pc of the granted request, paired with its rdata
    addr_t     inflight_pc_q;

    // word that came back while decode was stalled
    logic      hold_valid_q;
    addr_t     hold_pc_q;
    instr_t    hold_instr_q;

    logic      rsp_here;
    logic      rsp_keep;
    logic      new_req;
    logic      req;
    logic      gnt_ok;
    logic      granted_stale;
    bus_addr_t req_addr;

    // data for the outstanding request
    assign rsp_here = (state_q == WAIT_RVALID) && obi_rsp_i.rvalid;

    // old path or flushed right now
    assign rsp_keep = rsp_here && !drop_q && !redirect_i;

    // fresh request from idle, or chained in the data cycle
    // none during stall, none on the redirect cycle itself
    assign new_req = run_q && !stall_i && !redirect_i
                     && ((state_q == IDLE) || rsp_here);

    // once raised, req stays up until gnt regardless of stall
    assign req = (state_q == WAIT_GNT) || new_req;

    // pending request keeps its address, even across a redirect
    assign req_addr = (state_q == WAIT_GNT) ? pend_addr_q : pc_i;

    assign gnt_ok = req && obi_rsp_i.gnt;

    // grant for an address the pc has already moved away from
    assign granted_stale = (state_q == WAIT_GNT) && stale_q;

    // advance pc only when the granted address is the live one
    assign pc_take_o = gnt_ok && !granted_stale;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req) begin
                    state_d = obi_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                if (obi_rsp_i.gnt) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (obi_rsp_i.rvalid) begin
                    // chain the next fetch if allowed
                    if (req) begin
                        state_d = obi_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= IDLE;
            run_q        <= 1'b0;
            stale_q      <= 1'b0;
            drop_q       <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;

            // only meaningful while staying in WAIT_GNT
            stale_q <= (state_q == WAIT_GNT) && (state_d == WAIT_GNT)
                       && (stale_q || redirect_i);

            // every grant decides the fate of its own response
            if (gnt_ok) begin
                drop_q <= granted_stale || redirect_i;
            end else if (redirect_i) begin
                drop_q <= 1'b1;
            end

            // hold empties when shown or flushed
            if (redirect_i || !stall_i) begin
                hold_valid_q <= 1'b0;
            end else if (rsp_keep) begin
                hold_valid_q <= 1'b1;
            end
        end
    end

    // address and data capture
    always_ff @(posedge clk) begin
        // first cycle of a request that missed its grant
        if (req && !obi_rsp_i.gnt && (state_q != WAIT_GNT)) begin
            pend_addr_q <= pc_i;
        end
        if (gnt_ok) begin
            inflight_pc_q <= req_addr;
        end
        if (rsp_keep && stall_i) begin
            hold_pc_q    <= inflight_pc_q;
            hold_instr_q <= obi_rsp_i.rdata;
        end
    end

    // bus request, read only
    always_comb begin
        obi_req_o.req  = req;
        obi_req_o.addr = req_addr;
        obi_req_o.we   = 1'b0;
        obi_req_o.be   = BE_WORD;
    end

    // held word goes first, nothing else can return in that cycle
    always_comb begin
        if (hold_valid_q) begin
            fetch_o.valid = !stall_i && !redirect_i;
            fetch_o.pc    = hold_pc_q;
            fetch_o.instr = hold_instr_q;
        end else begin
            fetch_o.valid = rsp_keep && !stall_i;
            fetch_o.pc    = inflight_pc_q;
            fetch_o.instr = obi_rsp_i.rdata;
        end
    end

    // request up without gnt
    assign stall_gnt_o = req && !obi_rsp_i.gnt;

    // granted, data not back yet
    assign stall_rvalid_o = (state_q == WAIT_RVALID) && !obi_rsp_i.rvalid;

endmodule

// ==== hw/pc_gen.sv ====
// fetch PC register; BOOT_ADDR must be word aligned, redirect targets are taken as given
`timescale 1ns/1ns

module pc_gen #(
    parameter core_pkg::addr_t BOOT_ADDR = 32'h0000_0080
) (
    input  logic            clk,
    input  logic            reset,
    // pulse from fetch_ctrl when a fresh request is granted
    input  logic            pc_take_i,
    // redirect from a later stage
    input  logic            redirect_i,
    input  core_pkg::addr_t redirect_pc_i,
    output core_pkg::addr_t pc_o
);
    import core_pkg::*;

    // address of the next word to request
    addr_t pc_q;

    // sequential successor
    addr_t pc_seq;

    // one word ahead of the current pc
    assign pc_seq = pc_q + FETCH_STEP;

    always_ff @(posedge clk) begin
        if (reset) begin
            // restart at the boot vector
            pc_q <= BOOT_ADDR;
        end else if (redirect_i) begin
            // redirect wins over a same-cycle grant
            // that grant belonged to the old path
            pc_q <= redirect_pc_i;
        end else if (pc_take_i) begin
            // request for pc_q accepted by memory
            pc_q <= pc_seq;
        end
    end

    // only source of fetch addresses
    assign pc_o = pc_q;

endmodule

// ==== common/obi_pkg.sv ====
// OBI style read-only request and response; no error signalling, writes never issued
package obi_pkg;

    // byte address on the memory bus
    typedef logic [31:0] bus_addr_t;

    // read data returned with rvalid
    typedef logic [31:0] bus_data_t;

    // all four byte lanes, fetch always reads a full word
    localparam logic [3:0] BE_WORD = 4'b1111;

    // master to memory
    // we stays 0 and be stays BE_WORD for instruction fetch
    typedef struct packed {
        logic      req;
        bus_addr_t addr;
        logic      we;
        logic [3:0] be;
    } obi_req_t;

    // memory to master
    typedef struct packed {
        logic      gnt;
        logic      rvalid;
        bus_data_t rdata;
    } obi_rsp_t;

endpackage

// ==== common/core_pkg.sv ====
// fetch side types for a 32-bit core; word aligned fetch only, no compressed instructions
package core_pkg;

    // instruction address as seen by the core
    typedef logic [31:0] addr_t;

    // raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // addi x0, x0, 0
    // shown to decode whenever nothing valid is present
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // byte distance between sequential fetches
    localparam addr_t FETCH_STEP = 32'd4;

    // one fetched instruction headed for decode
    // valid low means pc and instr carry no meaning,
    // except instr reading as NOP once it passes the pipeline register
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
    } fetch_out_t;

    // value held by the pipeline register after reset or flush
    localparam fetch_out_t FETCH_EMPTY = '{
        valid: 1'b0,
        pc:    '0,
        instr: NOP_INSTR
    };

endpackage
